/* sim.f */
+incdir+include
design/if_pkg.sv
design/fetch_fifo.sv
design/prefetcher.sv
design/dummy_generator.sv
design/if_id_stage_reg.sv
design/if_stage.sv
sim/instr_mem_model.sv
sim/if_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
TOP       ?= if_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Exit status comes from the search for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/if_tb.sv */
`include "if_config.svh"

module if_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import if_pkg::*;

  localparam int unsigned NUM_TESTS = 5;
  localparam int unsigned SEED      = 32'h542b_668f;

  logic                clk;
  logic                rst_n;
  ctrl_fsm_t           ctrl_fsm;
  pc_targets_t         targets;
  instr_bus_req_t      bus_req;
  instr_bus_resp_t     bus_resp;
  logic                dummy_en;
  logic                id_ready;
  if_id_pipe_t         pipe;
  logic                mtvec_init;
  logic                busy;
  // Stimulus control
  logic                stall_en;
  string               test_name;
  int unsigned         err_start;
  int unsigned         failed;
  // Scoreboard state owned by the compare process
  int unsigned         errors;
  int unsigned         checks;
  int unsigned         nd_words;
  int unsigned         dummy_words;
  int unsigned         since_dummy;
  logic [`IF_XLEN-1:0] exp_pc;
  logic [`IF_XLEN-1:0] lfsr_ref;
  logic                rst_seen;
  // Requests in flight as counted from the bus handshake
  int unsigned         bus_out;

  if_stage dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_fsm_i       (ctrl_fsm),
    .targets_i        (targets),
    .bus_req_o        (bus_req),
    .bus_resp_i       (bus_resp),
    .dummy_en_i       (dummy_en),
    .id_ready_i       (id_ready),
    .if_id_pipe_o     (pipe),
    .csr_mtvec_init_o (mtvec_init),
    .if_busy_o        (busy)
  );

  instr_mem_model mem_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_req_i  (bus_req),
    .bus_resp_o (bus_resp)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Redirect target for the selected source
  function automatic logic [`IF_XLEN-1:0] target_of(input ctrl_fsm_t c, input pc_targets_t t);
    logic [`IF_XLEN-1:0] base;
    base = `IF_XLEN'(t.mtvec_addr) << (`IF_XLEN - `IF_MTVEC_WIDTH);
    case (c.pc_mux)
      PC_BOOT:     return t.boot_addr & ~`IF_XLEN'h3;
      PC_JUMP:     return t.jump_target;
      PC_BRANCH:   return t.branch_target;
      PC_MRET:     return t.mepc;
      PC_TRAP_EXC: return base;
      PC_TRAP_IRQ: return base | (`IF_XLEN'(c.irq_id) << 2);
      default:     return '0;
    endcase
  endfunction

  function automatic logic [`IF_XLEN-1:0] mem_word(input logic [`IF_XLEN-1:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic logic bus_err(input logic [`IF_XLEN-1:0] addr);
    return addr[31:28] == 4'hF;
  endfunction

  // Galois step that shifts right and folds the taps in on a 1 out
  function automatic logic [`IF_XLEN-1:0] lfsr_step(input logic [`IF_XLEN-1:0] s);
    logic [`IF_XLEN-1:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ `IF_LFSR_TAPS;
    end
    return n;
  endfunction

  task automatic check_val(input string what, input logic [`IF_XLEN-1:0] expected,
                           input logic [`IF_XLEN-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // Word taken by ID on this edge
  task automatic check_word;
    logic exp_dummy;
    exp_dummy = dummy_en && (since_dummy == `IF_DUMMY_EVERY);
    check_val("dummy flag", 32'(exp_dummy), 32'(pipe.dummy));
    if (pipe.dummy) begin
      check_val("dummy instr", lfsr_ref, pipe.instr);
      check_val("dummy abort_op", 0, 32'(pipe.abort_op));
      lfsr_ref    = lfsr_step(lfsr_ref);
      since_dummy = 0;
      dummy_words++;
    end else begin
      check_val("pc", exp_pc, pipe.pc);
      check_val("instr", mem_word(exp_pc), pipe.instr);
      check_val("abort_op", 32'(bus_err(exp_pc)), 32'(pipe.abort_op));
      exp_pc = exp_pc + `IF_XLEN'd4;
      nd_words++;
      if (dummy_en) begin
        since_dummy++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, ID readiness, compare and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Random ID stalls only while a test asks for them
  initial begin
    id_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        id_ready <= 1'b0;
      end else if (stall_en) begin
        id_ready <= ($urandom_range(3, 0) != 0);
      end else begin
        id_ready <= 1'b1;
      end
    end
  end

  // Values sampled at the edge are the ones of the cycle just ending
  initial begin
    errors      = 0;
    checks      = 0;
    nd_words    = 0;
    dummy_words = 0;
    since_dummy = 0;
    exp_pc      = '0;
    lfsr_ref    = `IF_LFSR_SEED;
    rst_seen    = 1'b0;
    bus_out     = 0;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        if (!rst_seen) begin
          rst_seen = 1'b1;
          check_val("bus req after reset", 0, 32'(bus_req.req));
          check_val("instr_valid after reset", 0, 32'(pipe.instr_valid));
          check_val("dummy_insert after reset", 0, 32'(dut_i.dummy_insert));
        end
        check_val("mtvec init", 32'(ctrl_fsm.pc_set && (ctrl_fsm.pc_mux == PC_BOOT)),
                  32'(mtvec_init));
        check_val("busy", 32'(bus_out != 0), 32'(busy));
        if (pipe.instr_valid && id_ready) begin
          check_word();
        end
        // New stream starts after any word taken in the pulse cycle
        if (ctrl_fsm.pc_set) begin
          exp_pc      = target_of(ctrl_fsm, targets);
          nd_words    = 0;
          dummy_words = 0;
        end
        // Grant taken on this edge, response done on this edge
        if (bus_req.req && bus_resp.gnt) begin
          bus_out++;
        end
        if (bus_resp.rvalid) begin
          bus_out--;
        end
      end else begin
        bus_out = 0;
      end
    end
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk);
    $display("Timeout in test %s, fetch stopped making progress", test_name);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic redirect(input pc_mux_e mux, input logic [`IF_IRQ_ID_WIDTH-1:0] irq);
    @(posedge clk);
    ctrl_fsm.pc_set <= 1'b1;
    ctrl_fsm.pc_mux <= mux;
    ctrl_fsm.irq_id <= irq;
    @(posedge clk);
    ctrl_fsm.pc_set <= 1'b0;
  endtask

  task automatic wait_words(input int unsigned n);
    do begin
      @(posedge clk);
    end while (nd_words < n);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test;
    if (errors != err_start) begin
      failed++;
    end
    $display("%s: %0d words, %0d dummies, %0d errors", test_name, nd_words, dummy_words,
             errors - err_start);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n    = 1'b0;
    ctrl_fsm = '0;
    targets  = '0;
    dummy_en = 1'b0;
    stall_en = 1'b0;
    failed   = 0;
    begin_test("boot");
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Unaligned boot address whose low bits get dropped
    targets.boot_addr <= 32'h0000_1002;
    redirect(PC_BOOT, '0);
    wait_words(12);
    end_test();

    // Short runs so that requests are still in flight at each pulse
    begin_test("redirect");
    targets.jump_target   <= 32'h2000_0100;
    targets.branch_target <= 32'h0000_3404;
    targets.mepc          <= 32'h4000_0040;
    targets.mtvec_addr    <= 25'h001_2345;
    redirect(PC_JUMP, '0);
    wait_words(3);
    redirect(PC_BRANCH, '0);
    wait_words(3);
    redirect(PC_MRET, '0);
    wait_words(3);
    redirect(PC_TRAP_EXC, '0);
    wait_words(3);
    redirect(PC_TRAP_IRQ, 5'd7);
    wait_words(3);
    end_test();

    begin_test("stall and halt");
    targets.jump_target <= 32'h0000_8000;
    redirect(PC_JUMP, '0);
    stall_en <= 1'b1;
    do begin
      @(posedge clk);
      // Halt spans of random length
      if ($urandom_range(7, 0) == 0) begin
        ctrl_fsm.halt_if <= !ctrl_fsm.halt_if;
      end
    end while (nd_words < 40);
    ctrl_fsm.halt_if <= 1'b0;
    stall_en         <= 1'b0;
    // ID ready again before the next pulse
    repeat (3) @(posedge clk);
    end_test();

    begin_test("bus error");
    targets.jump_target <= 32'hF000_0200;
    redirect(PC_JUMP, '0);
    wait_words(6);
    end_test();

    // Enabled after the pulse, so every counted word is fetched with it on
    begin_test("dummy");
    targets.branch_target <= 32'h0000_5000;
    redirect(PC_BRANCH, '0);
    dummy_en <= 1'b1;
    wait_words(20);
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS, failed, checks,
             errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim/instr_mem_model.sv */
`include "if_config.svh"

module instr_mem_model (
  input  logic                    clk,
  input  logic                    rst_n,
  input  if_pkg::instr_bus_req_t  bus_req_i,
  output if_pkg::instr_bus_resp_t bus_resp_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import if_pkg::*;

  // Granted addresses waiting for their response, oldest first
  logic [`IF_XLEN-1:0] pending_q [$];
  logic [`IF_XLEN-1:0] resp_addr;

  ////////////////////////////////////////////////////////////
  // Grant and response timing
  ////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q.delete();
      bus_resp_o <= '0;
    end else begin
      // Request taken on req and gnt
      if (bus_req_i.req && bus_resp_o.gnt) begin
        pending_q.push_back(bus_req_i.addr);
      end
      // Grant about three cycles in four, whether or not req is up
      bus_resp_o.gnt    <= ($urandom_range(3, 0) != 0);
      bus_resp_o.rvalid <= 1'b0;
      // Responses keep request order, random gaps between them
      if ((pending_q.size() != 0) && ($urandom_range(2, 0) != 0)) begin
        resp_addr = pending_q.pop_front();
        bus_resp_o.rvalid <= 1'b1;
        bus_resp_o.rdata  <= resp_addr ^ 32'hA5A5_0000;
        // Top nibble F is an unmapped region
        bus_resp_o.err    <= (resp_addr[31:28] == 4'hF);
      end
    end
  end

endmodule

/* design/if_stage.sv */
`include "if_config.svh"

module if_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  if_pkg::ctrl_fsm_t       ctrl_fsm_i,
  input  if_pkg::pc_targets_t     targets_i,
  output if_pkg::instr_bus_req_t  bus_req_o,
  input  if_pkg::instr_bus_resp_t bus_resp_i,
  input  logic                    dummy_en_i,
  input  logic                    id_ready_i,
  output if_pkg::if_id_pipe_t     if_id_pipe_o,
  output logic                    csr_mtvec_init_o,
  output logic                    if_busy_o
);
  import if_pkg::*;

  // Prefetcher to IF/ID register
  logic                fetch_valid;
  fetch_word_t         fetch_word;
  logic                fetch_ack;
  // Dummy generator handshake
  logic                dummy_insert;
  logic [`IF_XLEN-1:0] dummy_word;
  logic                instr_issued;
  logic                issued_dummy;

  prefetcher prefetcher_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_fsm_i       (ctrl_fsm_i),
    .targets_i        (targets_i),
    .bus_resp_i       (bus_resp_i),
    .fetch_ack_i      (fetch_ack),
    .bus_req_o        (bus_req_o),
    .fetch_valid_o    (fetch_valid),
    .fetch_word_o     (fetch_word),
    .busy_o           (if_busy_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  dummy_generator dummy_generator_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .dummy_en_i     (dummy_en_i),
    .instr_issued_i (instr_issued),
    .issued_dummy_i (issued_dummy),
    .dummy_insert_o (dummy_insert),
    .dummy_word_o   (dummy_word)
  );

  if_id_stage_reg if_id_stage_reg_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_fsm_i     (ctrl_fsm_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_word_i   (fetch_word),
    .dummy_insert_i (dummy_insert),
    .dummy_word_i   (dummy_word),
    .id_ready_i     (id_ready_i),
    .fetch_ack_o    (fetch_ack),
    .instr_issued_o (instr_issued),
    .issued_dummy_o (issued_dummy),
    .if_id_pipe_o   (if_id_pipe_o)
  );

endmodule

/* design/if_id_stage_reg.sv */
`include "if_config.svh"

module if_id_stage_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  logic                fetch_valid_i,
  input  if_pkg::fetch_word_t fetch_word_i,
  input  logic                dummy_insert_i,
  input  logic [`IF_XLEN-1:0] dummy_word_i,
  input  logic                id_ready_i,
  output logic                fetch_ack_o,
  output logic                instr_issued_o,
  output logic                issued_dummy_o,
  output if_pkg::if_id_pipe_t if_id_pipe_o
);
  import if_pkg::*;

  logic        issue;
  if_id_pipe_t pipe_n;

  ////////////////////////////////////////////////////////////
  // Issue decision
  ////////////////////////////////////////////////////////////

  // Nothing moves while halted or while the buffer is being flushed
  assign issue = (fetch_valid_i || dummy_insert_i) && id_ready_i &&
                 !ctrl_fsm_i.halt_if && !ctrl_fsm_i.pc_set;

  // Dummy wins; the fetched word stays in the buffer for later
  assign fetch_ack_o    = issue && !dummy_insert_i;
  assign issued_dummy_o = issue && dummy_insert_i;
  // Drives the dummy interval counter
  assign instr_issued_o = issue;

  // Next register content
  always_comb begin
    pipe_n             = '0;
    pipe_n.instr_valid = 1'b1;
    if (dummy_insert_i) begin
      // Dummy borrows the pc of the word waiting behind it
      pipe_n.pc    = fetch_valid_i ? fetch_word_i.pc : '0;
      pipe_n.instr = dummy_word_i;
      pipe_n.dummy = 1'b1;
    end else begin
      pipe_n.pc       = fetch_word_i.pc;
      pipe_n.instr    = fetch_word_i.rdata;
      // bus error turns into an abort in ID
      pipe_n.abort_op = fetch_word_i.err;
    end
  end

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o <= '0;
    end else if (issue) begin
      if_id_pipe_o <= pipe_n;
    end else if (id_ready_i) begin
      // ID consumed the last word and nothing new came
      if_id_pipe_o.instr_valid <= 1'b0;
    end
  end

  // A stalled ID freezes the register and the word waiting behind it
  a_hold_when_stalled : assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i && fetch_valid_i && !ctrl_fsm_i.pc_set |=>
      $stable(if_id_pipe_o) && fetch_valid_i && $stable(fetch_word_i))
    else $error("if_id_stage_reg: register or fetch word changed while ID stalled");

endmodule

/* design/dummy_generator.sv */
`include "if_config.svh"

module dummy_generator (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dummy_en_i,
  input  logic                instr_issued_i,
  input  logic                issued_dummy_i,
  output logic                dummy_insert_o,
  output logic [`IF_XLEN-1:0] dummy_word_o
);

  localparam int unsigned CNT_W = $clog2(`IF_DUMMY_EVERY + 1);

  logic [CNT_W-1:0]    issue_cnt_q;
  logic                cnt_full;
  logic [`IF_XLEN-1:0] lfsr_q;
  logic [`IF_XLEN-1:0] lfsr_next;

  assign cnt_full = (issue_cnt_q == CNT_W'(`IF_DUMMY_EVERY));

  // Request stays up until the dummy leaves, unless insertion is switched off
  assign dummy_insert_o = dummy_en_i && cnt_full;

  // Galois step, right shift with feedback from bit 0
  assign lfsr_next = {1'b0, lfsr_q[`IF_XLEN-1:1]} ^
                     (lfsr_q[0] ? `IF_LFSR_TAPS : '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_cnt_q <= '0;
      lfsr_q      <= `IF_LFSR_SEED;
    end else begin
      if (issued_dummy_i) begin
        // New interval starts, next dummy gets a fresh word
        issue_cnt_q <= '0;
        lfsr_q      <= lfsr_next;
      end else if (instr_issued_i && dummy_en_i && !cnt_full) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end
    end
  end

  // Word for the next dummy
  assign dummy_word_o = lfsr_q;

  a_dummy_requested : assert property (@(posedge clk) disable iff (!rst_n)
    issued_dummy_i |-> dummy_insert_o)
    else $error("dummy_generator: dummy issued without a request");

endmodule

/* design/prefetcher.sv */
`include "if_config.svh"

module prefetcher (
  input  logic                    clk,
  input  logic                    rst_n,
  input  if_pkg::ctrl_fsm_t       ctrl_fsm_i,
  input  if_pkg::pc_targets_t     targets_i,
  input  if_pkg::instr_bus_resp_t bus_resp_i,
  input  logic                    fetch_ack_i,
  output if_pkg::instr_bus_req_t  bus_req_o,
  output logic                    fetch_valid_o,
  output if_pkg::fetch_word_t     fetch_word_o,
  output logic                    busy_o,
  output logic                    csr_mtvec_init_o
);
  import if_pkg::*;

  localparam int unsigned OUT_W = $clog2(`IF_MAX_OUTSTANDING + 1);
  localparam int unsigned CNT_W = $clog2(`IF_FIFO_DEPTH + 1);

  logic [`IF_XLEN-1:0] branch_addr;
  logic [`IF_XLEN-1:0] req_addr;
  logic [`IF_XLEN-1:0] next_pc_q;
  logic                fetch_active_q;
  // All requests in flight, and those whose responses get dropped
  logic [OUT_W-1:0]    out_cnt_q;
  logic [OUT_W-1:0]    discard_cnt_q;
  logic [OUT_W-1:0]    live_cnt;
  logic [CNT_W-1:0]    resp_cnt;
  logic                room_ok;
  logic                req;
  logic                req_taken;
  logic                resp_keep;
  logic [`IF_XLEN-1:0] resp_pc;
  fetch_word_t         resp_word;
  logic                resp_empty;

  ////////////////////////////////////////////////////////////
  // Branch address
  ////////////////////////////////////////////////////////////

  always_comb begin
    branch_addr = {targets_i.boot_addr[`IF_XLEN-1:2], 2'b00};
    unique case (ctrl_fsm_i.pc_mux)
      PC_BOOT:     branch_addr = {targets_i.boot_addr[`IF_XLEN-1:2], 2'b00};
      PC_JUMP:     branch_addr = targets_i.jump_target;
      PC_BRANCH:   branch_addr = targets_i.branch_target;
      PC_MRET:     branch_addr = targets_i.mepc;
      // Exceptions share the trap base
      PC_TRAP_EXC: branch_addr = {targets_i.mtvec_addr, 7'h00};
      // Interrupts are vectored, one word per index
      PC_TRAP_IRQ: branch_addr = {targets_i.mtvec_addr, ctrl_fsm_i.irq_id, 2'b00};
      default: ;
    endcase
  end

  // mtvec gets initialised once, on the boot redirect
  assign csr_mtvec_init_o = ctrl_fsm_i.pc_set && (ctrl_fsm_i.pc_mux == PC_BOOT);

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  assign live_cnt = out_cnt_q - discard_cnt_q;
  // Every live response must find a free buffer slot
  // On pc_set the buffer is flushed and nothing in flight is live
  assign room_ok  = ctrl_fsm_i.pc_set ||
                    ((32'(resp_cnt) + 32'(live_cnt)) < `IF_FIFO_DEPTH);
  // New target goes out in the pc_set cycle itself
  assign req_addr = ctrl_fsm_i.pc_set ? branch_addr : next_pc_q;
  assign req      = (fetch_active_q || ctrl_fsm_i.pc_set) && room_ok &&
                    (out_cnt_q < OUT_W'(`IF_MAX_OUTSTANDING));

  assign bus_req_o = '{req: req, addr: req_addr};
  assign req_taken = req && bus_resp_i.gnt;

  // Stale responses are dropped, as is anything arriving with pc_set
  assign resp_keep = bus_resp_i.rvalid && (discard_cnt_q == '0) && !ctrl_fsm_i.pc_set;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_active_q <= 1'b0;
      next_pc_q      <= '0;
      out_cnt_q      <= '0;
      discard_cnt_q  <= '0;
    end else begin
      // Idle until the first redirect
      if (ctrl_fsm_i.pc_set) begin
        fetch_active_q <= 1'b1;
      end
      if (req_taken) begin
        next_pc_q <= req_addr + `IF_XLEN'd4;
      end else if (ctrl_fsm_i.pc_set) begin
        next_pc_q <= branch_addr;
      end
      out_cnt_q <= out_cnt_q + OUT_W'(req_taken) - OUT_W'(bus_resp_i.rvalid);
      // Whatever is still outstanding from before the pulse becomes stale
      if (ctrl_fsm_i.pc_set) begin
        discard_cnt_q <= out_cnt_q - OUT_W'(bus_resp_i.rvalid);
      end else if (bus_resp_i.rvalid && (discard_cnt_q != '0)) begin
        discard_cnt_q <= discard_cnt_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  // pc of each live request, oldest first
  fetch_fifo #(
    .payload_t (logic [`IF_XLEN-1:0]),
    .DEPTH     (`IF_MAX_OUTSTANDING)
  ) addr_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (ctrl_fsm_i.pc_set),
    .push_i  (req_taken),
    .data_i  (req_addr),
    .pop_i   (resp_keep),
    .data_o  (resp_pc),
    .empty_o (),
    .count_o ()
  );

  assign resp_word = '{pc: resp_pc, rdata: bus_resp_i.rdata, err: bus_resp_i.err};

  // Prefetch buffer
  fetch_fifo #(
    .payload_t (fetch_word_t),
    .DEPTH     (`IF_FIFO_DEPTH)
  ) resp_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (ctrl_fsm_i.pc_set),
    .push_i  (resp_keep),
    .data_i  (resp_word),
    .pop_i   (fetch_valid_o && fetch_ack_i),
    .data_o  (fetch_word_o),
    .empty_o (resp_empty),
    .count_o (resp_cnt)
  );

  assign fetch_valid_o = !resp_empty;
  assign busy_o        = (out_cnt_q != '0);

  a_rvalid_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_i.rvalid |-> out_cnt_q != '0)
    else $error("prefetcher: rvalid with no request outstanding");

endmodule

/* design/fetch_fifo.sv */
`include "if_config.svh"

module fetch_fifo #(
  parameter type         payload_t = logic [`IF_XLEN-1:0],
  parameter int unsigned DEPTH     = `IF_FIFO_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  payload_t                   data_i,
  input  logic                       pop_i,
  output payload_t                   data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  // State seen by this cycle's push and pop, after a flush
  logic [PTR_W-1:0] rd_base;
  logic [PTR_W-1:0] wr_base;
  logic [CNT_W-1:0] cnt_base;
  logic             do_pop;

  // Pointer wrap for a depth that need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // A flush empties the buffer; a push in the same cycle lands in slot 0
  assign rd_base  = flush_i ? '0 : rd_ptr_q;
  assign wr_base  = flush_i ? '0 : wr_ptr_q;
  assign cnt_base = flush_i ? '0 : cnt_q;
  // Popping a flushed entry is meaningless
  assign do_pop   = pop_i && !flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      rd_ptr_q <= do_pop ? ptr_inc(rd_base) : rd_base;
      wr_ptr_q <= push_i ? ptr_inc(wr_base) : wr_base;
      cnt_q    <= cnt_base + CNT_W'(push_i) - CNT_W'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_base] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign count_o = cnt_q;

  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    push_i && !flush_i && !pop_i |-> cnt_q < CNT_W'(DEPTH))
    else $error("fetch_fifo: push while full");

  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
    pop_i && !flush_i |-> cnt_q != '0)
    else $error("fetch_fifo: pop while empty");

endmodule

/* design/if_pkg.sv */
`include "if_config.svh"

package if_pkg;

  // Next-PC source selected on a pc_set pulse
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Controller to IF stage
  typedef struct packed {
    logic                        pc_set;   // pulse, also flushes the buffer
    pc_mux_e                     pc_mux;
    logic [`IF_IRQ_ID_WIDTH-1:0] irq_id;
    logic                        halt_if;  // level
  } ctrl_fsm_t;

  // Candidate redirect targets
  typedef struct packed {
    logic [`IF_XLEN-1:0]        boot_addr;
    logic [`IF_XLEN-1:0]        jump_target;
    logic [`IF_XLEN-1:0]        branch_target;
    logic [`IF_XLEN-1:0]        mepc;
    logic [`IF_MTVEC_WIDTH-1:0] mtvec_addr;
  } pc_targets_t;

  // Instruction bus, core side request
  typedef struct packed {
    logic                req;
    logic [`IF_XLEN-1:0] addr;
  } instr_bus_req_t;

  // Instruction bus, memory side strobes and data
  typedef struct packed {
    logic                gnt;
    logic                rvalid;
    logic [`IF_XLEN-1:0] rdata;
    logic                err;
  } instr_bus_resp_t;

  // Buffered response paired with the pc of its request
  typedef struct packed {
    logic [`IF_XLEN-1:0] pc;
    logic [`IF_XLEN-1:0] rdata;
    logic                err;
  } fetch_word_t;

  // IF/ID pipeline register content
  typedef struct packed {
    logic                instr_valid;
    logic [`IF_XLEN-1:0] pc;
    logic [`IF_XLEN-1:0] instr;
    logic                dummy;
    logic                abort_op;
  } if_id_pipe_t;

endpackage

/* include/if_config.svh */
`ifndef IF_CONFIG_SVH
`define IF_CONFIG_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Address and instruction word width
`define IF_XLEN            32
// Trap base bits, placed at the top of the target address
`define IF_MTVEC_WIDTH     25
// Vectored interrupt index width
`define IF_IRQ_ID_WIDTH    5

////////////////////////////////////////////////////////////
// Prefetch and dummy insertion
////////////////////////////////////////////////////////////

`define IF_FIFO_DEPTH      3
`define IF_MAX_OUTSTANDING 2
// Non-dummy issues between two dummies
`define IF_DUMMY_EVERY     4
// Galois LFSR, shifts right, taps XORed in when bit 0 falls out
`define IF_LFSR_SEED       32'h1
`define IF_LFSR_TAPS       32'h8020_0003

`endif
